// File: verilog/date_pkg.sv
package date_pkg;

    ////////////////////////////////////////
    // Display scan
    ////////////////////////////////////////

    // Scan positions from right to left on the display
    typedef enum logic [1:0] {
        slot_0 = 2'd0,
        slot_1 = 2'd1,
        slot_2 = 2'd2,
        slot_3 = 2'd3
    } scan_slot_e;

    // Meaning of show_year
    typedef enum logic {
        mode_day_month = 1'b0,
        mode_year      = 1'b1
    } display_mode_e;

    // Segment order is {dp, g, f, e, d, c, b, a}
    // A low bit lights a segment
    localparam logic [7:0] seg_blank = 8'hff;

    // Active-low anode enables
    localparam logic [3:0] anode_off = 4'hf;

    // Digits 0 to 9 with the decimal point dark
    localparam logic [7:0] seg_font [10] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,
        8'h92, 8'h82, 8'hf8, 8'h80, 8'h90
    };

    ////////////////////////////////////////
    // Calendar
    ////////////////////////////////////////

    // Month lengths from January with February at 28
    // Leap years add one day to February
    // Two-digit year divisible by four means an even tens digit with
    // ones 0, 4 or 8, or an odd tens digit with ones 2 or 6
    localparam logic [4:0] month_days [12] = '{
        5'd31, 5'd28, 5'd31, 5'd30, 5'd31, 5'd30,
        5'd31, 5'd31, 5'd30, 5'd31, 5'd30, 5'd31
    };

    // Reset date 01/01/00 in BCD
    localparam logic [7:0] first_day   = 8'h01;
    localparam logic [7:0] first_month = 8'h01;
    localparam logic [7:0] first_year  = 8'h00;

endpackage

// File: verilog/seg_decoder.sv
`timescale 1ns/1ps

module seg_decoder #(
    parameter bit blank_zero = 1'b0
) (
    input  logic [3:0] digit,
    output logic [7:0] seg
);

    logic is_digit;
    logic hide_zero;

    ////////////////////////////////////////
    // Code classification
    ////////////////////////////////////////

    assign is_digit = (digit <= 4'd9);

    // Leading zero suppression on the tens positions
    assign hide_zero = blank_zero && (digit == 4'd0);

    ////////////////////////////////////////
    // Font lookup
    ////////////////////////////////////////

    always_comb
    begin
        if (!is_digit)
        begin
            // Codes A to F are not BCD
            seg = date_pkg::seg_blank;
        end
        else if (hide_zero)
        begin
            seg = date_pkg::seg_blank;
        end
        else
        begin
            seg = date_pkg::seg_font[digit];
        end
    end

endmodule

// File: verilog/date_counter.sv
`timescale 1ns/1ps

module date_counter (
    input  logic       clk_ctl,
    input  logic       rst_n,
    input  logic       advance,
    input  logic       load,
    input  logic [3:0] load_day_ten,
    input  logic [3:0] load_day_one,
    input  logic [3:0] load_month_ten,
    input  logic [3:0] load_month_one,
    input  logic [3:0] load_year_ten,
    input  logic [3:0] load_year_one,
    output logic [3:0] day_ten,
    output logic [3:0] day_one,
    output logic [3:0] month_ten,
    output logic [3:0] month_one,
    output logic [3:0] year_ten,
    output logic [3:0] year_one
);

    logic [7:0] day_bin;
    logic [7:0] month_bin;
    logic [3:0] month_idx;
    logic       is_leap;
    logic [4:0] last_day;
    logic       month_end;

    logic [3:0] next_day_ten;
    logic [3:0] next_day_one;
    logic [3:0] next_month_ten;
    logic [3:0] next_month_one;
    logic [3:0] next_year_ten;
    logic [3:0] next_year_one;

    logic       month_ok;
    logic       digits_ok;

    ////////////////////////////////////////
    // Month length lookup
    ////////////////////////////////////////

    assign day_bin   = 8'(day_ten) * 8'd10 + 8'(day_one);
    assign month_bin = 8'(month_ten) * 8'd10 + 8'(month_one);

    // Unknown months fall back to the January length
    assign month_idx = (month_bin >= 8'd1 && month_bin <= 8'd12) ?
                       4'(month_bin - 8'd1) : 4'd0;

    // Divisible by four worked out on the BCD digits directly
    always_comb
    begin
        if (year_ten[0])
            is_leap = (year_one == 4'd2) || (year_one == 4'd6);
        else
            is_leap = (year_one == 4'd0) || (year_one == 4'd4) || (year_one == 4'd8);
    end

    assign last_day = (month_idx == 4'd1 && is_leap) ?
                      date_pkg::month_days[month_idx] + 5'd1 :
                      date_pkg::month_days[month_idx];

    // Also catches a loaded day past the month length
    assign month_end = (day_bin >= {3'b000, last_day});

    ////////////////////////////////////////
    // Next date on advance
    ////////////////////////////////////////

    always_comb
    begin
        next_day_ten   = day_ten;
        next_day_one   = day_one;
        next_month_ten = month_ten;
        next_month_one = month_one;
        next_year_ten  = year_ten;
        next_year_one  = year_one;

        if (month_end)
        begin
            next_day_ten = date_pkg::first_day[7:4];
            next_day_one = date_pkg::first_day[3:0];

            if (month_ten == 4'd1 && month_one == 4'd2)
            begin
                // December rolls into a new year
                next_month_ten = date_pkg::first_month[7:4];
                next_month_one = date_pkg::first_month[3:0];
                if (year_one == 4'd9)
                begin
                    next_year_one = 4'd0;
                    next_year_ten = (year_ten == 4'd9) ? 4'd0 : year_ten + 4'd1;
                end
                else
                begin
                    next_year_one = year_one + 4'd1;
                end
            end
            else if (month_one == 4'd9)
            begin
                next_month_ten = month_ten + 4'd1;
                next_month_one = 4'd0;
            end
            else
            begin
                next_month_one = month_one + 4'd1;
            end
        end
        else if (day_one == 4'd9)
        begin
            next_day_ten = day_ten + 4'd1;
            next_day_one = 4'd0;
        end
        else
        begin
            next_day_one = day_one + 4'd1;
        end
    end

    ////////////////////////////////////////
    // Date registers
    ////////////////////////////////////////

    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            day_ten   <= date_pkg::first_day[7:4];
            day_one   <= date_pkg::first_day[3:0];
            month_ten <= date_pkg::first_month[7:4];
            month_one <= date_pkg::first_month[3:0];
            year_ten  <= date_pkg::first_year[7:4];
            year_one  <= date_pkg::first_year[3:0];
        end
        else if (load)
        begin
            // Load wins over a same-cycle advance
            day_ten   <= load_day_ten;
            day_one   <= load_day_one;
            month_ten <= load_month_ten;
            month_one <= load_month_one;
            year_ten  <= load_year_ten;
            year_one  <= load_year_one;
        end
        else if (advance)
        begin
            day_ten   <= next_day_ten;
            day_one   <= next_day_one;
            month_ten <= next_month_ten;
            month_one <= next_month_one;
            year_ten  <= next_year_ten;
            year_one  <= next_year_one;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assign month_ok = (month_ten == 4'd0 && month_one != 4'd0 && month_one <= 4'd9) ||
                      (month_ten == 4'd1 && month_one <= 4'd2);

    assign digits_ok = (day_ten <= 4'd9) && (day_one <= 4'd9) &&
                       (month_ten <= 4'd9) && (month_one <= 4'd9) &&
                       (year_ten <= 4'd9) && (year_one <= 4'd9);

    // Counting never leaves BCD once the digits are valid
    a_digits_bcd: assert property (@(posedge clk_ctl) disable iff (!rst_n)
        !load && digits_ok |=> digits_ok);

    // Month wrap keeps 01 to 12 without a load
    a_month_range: assert property (@(posedge clk_ctl) disable iff (!rst_n)
        !load && month_ok |=> month_ok);

endmodule

// File: verilog/display_scan.sv
`timescale 1ns/1ps

module display_scan (
    input  logic       clk_ctl,
    input  logic       rst_n,
    input  logic       show_year,
    input  logic [7:0] seg_day_one,
    input  logic [7:0] seg_day_ten,
    input  logic [7:0] seg_month_one,
    input  logic [7:0] seg_month_ten,
    input  logic [7:0] seg_year_one,
    input  logic [7:0] seg_year_ten,
    output logic [7:0] seg,
    output logic [3:0] an
);

    date_pkg::scan_slot_e    slot;
    date_pkg::display_mode_e mode;

    logic [7:0] next_seg;
    logic [3:0] next_an;

    assign mode = date_pkg::display_mode_e'(show_year);

    ////////////////////////////////////////
    // Slot counter
    ////////////////////////////////////////

    // Free running at one position per clock
    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
            slot <= date_pkg::slot_0;
        else
            slot <= date_pkg::scan_slot_e'(slot + 2'd1);
    end

    ////////////////////////////////////////
    // Slot to digit mapping
    ////////////////////////////////////////

    always_comb
    begin
        next_seg = date_pkg::seg_blank;
        next_an  = date_pkg::anode_off;

        case (slot)
            date_pkg::slot_0:
            begin
                next_an  = 4'b1110;
                next_seg = (mode == date_pkg::mode_year) ? seg_year_one : seg_day_one;
            end
            date_pkg::slot_1:
            begin
                next_an  = 4'b1101;
                next_seg = (mode == date_pkg::mode_year) ? seg_year_ten : seg_day_ten;
            end
            date_pkg::slot_2:
            begin
                // Upper half stays dark in year mode
                if (mode == date_pkg::mode_day_month)
                begin
                    next_an  = 4'b1011;
                    next_seg = seg_month_one;
                end
            end
            date_pkg::slot_3:
            begin
                if (mode == date_pkg::mode_day_month)
                begin
                    next_an  = 4'b0111;
                    next_seg = seg_month_ten;
                end
            end
        endcase
    end

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            seg <= date_pkg::seg_blank;
            an  <= date_pkg::anode_off;
        end
        else
        begin
            seg <= next_seg;
            an  <= next_an;
        end
    end

    // Never two digits driven at once
    a_one_anode: assert property (@(posedge clk_ctl) disable iff (!rst_n)
        (an == date_pkg::anode_off) || $onehot(~an));

endmodule

// File: verilog/date_display.sv
`timescale 1ns/1ps

module date_display (
    input  logic       clk_ctl,
    input  logic       rst_n,
    input  logic       advance,
    input  logic       load,
    input  logic [3:0] load_day_ten,
    input  logic [3:0] load_day_one,
    input  logic [3:0] load_month_ten,
    input  logic [3:0] load_month_one,
    input  logic [3:0] load_year_ten,
    input  logic [3:0] load_year_one,
    input  logic       show_year,
    output logic [7:0] seg,
    output logic [3:0] an
);

    logic [3:0] day_ten;
    logic [3:0] day_one;
    logic [3:0] month_ten;
    logic [3:0] month_one;
    logic [3:0] year_ten;
    logic [3:0] year_one;

    logic [7:0] seg_day_one;
    logic [7:0] seg_day_ten;
    logic [7:0] seg_month_one;
    logic [7:0] seg_month_ten;
    logic [7:0] seg_year_one;
    logic [7:0] seg_year_ten;

    ////////////////////////////////////////
    // Calendar
    ////////////////////////////////////////

    date_counter u_counter (
        .clk_ctl        (clk_ctl),
        .rst_n          (rst_n),
        .advance        (advance),
        .load           (load),
        .load_day_ten   (load_day_ten),
        .load_day_one   (load_day_one),
        .load_month_ten (load_month_ten),
        .load_month_one (load_month_one),
        .load_year_ten  (load_year_ten),
        .load_year_one  (load_year_one),
        .day_ten        (day_ten),
        .day_one        (day_one),
        .month_ten      (month_ten),
        .month_one      (month_one),
        .year_ten       (year_ten),
        .year_one       (year_one)
    );

    ////////////////////////////////////////
    // Decoders
    ////////////////////////////////////////

    // Tens of day and month drop a leading zero
    // Year tens keeps its zero
    seg_decoder #(.blank_zero(1'b0)) u_dec_day_one   (.digit(day_one),   .seg(seg_day_one));
    seg_decoder #(.blank_zero(1'b1)) u_dec_day_ten   (.digit(day_ten),   .seg(seg_day_ten));
    seg_decoder #(.blank_zero(1'b0)) u_dec_month_one (.digit(month_one), .seg(seg_month_one));
    seg_decoder #(.blank_zero(1'b1)) u_dec_month_ten (.digit(month_ten), .seg(seg_month_ten));
    seg_decoder #(.blank_zero(1'b0)) u_dec_year_one  (.digit(year_one),  .seg(seg_year_one));
    seg_decoder #(.blank_zero(1'b0)) u_dec_year_ten  (.digit(year_ten),  .seg(seg_year_ten));

    ////////////////////////////////////////
    // Scanner
    ////////////////////////////////////////

    display_scan u_scan (
        .clk_ctl       (clk_ctl),
        .rst_n         (rst_n),
        .show_year     (show_year),
        .seg_day_one   (seg_day_one),
        .seg_day_ten   (seg_day_ten),
        .seg_month_one (seg_month_one),
        .seg_month_ten (seg_month_ten),
        .seg_year_one  (seg_year_one),
        .seg_year_ten  (seg_year_ten),
        .seg           (seg),
        .an            (an)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_ctl,
    output logic rst_n
);

    // 4 ns period
    initial
    begin
        clk_ctl = 1'b0;
        forever #2 clk_ctl = ~clk_ctl;
    end

    // Reset held over the first three rising edges
    initial
    begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_ctl);
        rst_n <= 1'b1;
    end

endmodule

// File: dv/tb_date_display.sv
`timescale 1ns/1ps

module tb_date_display;

    logic       clk_ctl;
    logic       rst_n;
    logic       advance;
    logic       load;
    logic [3:0] load_day_ten;
    logic [3:0] load_day_one;
    logic [3:0] load_month_ten;
    logic [3:0] load_month_one;
    logic [3:0] load_year_ten;
    logic [3:0] load_year_one;
    logic       show_year;
    logic [7:0] seg;
    logic [3:0] an;

    // Reference date and scan position
    int                      m_day;
    int                      m_month;
    int                      m_year;
    date_pkg::scan_slot_e    m_slot;
    date_pkg::display_mode_e mode_now;
    logic [7:0]              exp_seg;
    logic [3:0]              exp_an;

    logic [23:0] load_digits;
    logic [23:0] held_load_digits;
    logic [23:0] counter_digits;

    logic checking = 1'b0;
    int   error_count = 0;
    int   tests_run = 0;
    int   tests_failed = 0;

    tb_clock_gen u_clock (.clk_ctl(clk_ctl), .rst_n(rst_n));

    date_display uut (
        .clk_ctl        (clk_ctl),
        .rst_n          (rst_n),
        .advance        (advance),
        .load           (load),
        .load_day_ten   (load_day_ten),
        .load_day_one   (load_day_one),
        .load_month_ten (load_month_ten),
        .load_month_one (load_month_one),
        .load_year_ten  (load_year_ten),
        .load_year_one  (load_year_one),
        .show_year      (show_year),
        .seg            (seg),
        .an             (an)
    );

    assign mode_now       = date_pkg::display_mode_e'(show_year);
    assign load_digits    = {load_day_ten, load_day_one, load_month_ten,
                             load_month_one, load_year_ten, load_year_one};
    assign counter_digits = {uut.day_ten, uut.day_one, uut.month_ten,
                             uut.month_one, uut.year_ten, uut.year_one};

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Leap year when the two-digit year divides by four
    function automatic int days_in(input int month, input int year);
        int len;
        len = (month >= 1 && month <= 12) ? date_pkg::month_days[month - 1] : 31;
        if (month == 2 && year % 4 == 0)
            len = len + 1;
        return len;
    endfunction

    function automatic logic [7:0] digit_pattern(input int value, input bit hide_zero);
        if (hide_zero && value == 0)
            return date_pkg::seg_blank;
        return date_pkg::seg_font[value];
    endfunction

    function automatic logic [7:0] expected_seg(input date_pkg::scan_slot_e slot,
                                                input date_pkg::display_mode_e mode,
                                                input int day, input int month, input int year);
        if (mode == date_pkg::mode_year)
            return (slot == date_pkg::slot_0) ? digit_pattern(year % 10, 1'b0) :
                   (slot == date_pkg::slot_1) ? digit_pattern(year / 10, 1'b0) :
                   date_pkg::seg_blank;
        case (slot)
            date_pkg::slot_0: return digit_pattern(day % 10, 1'b0);
            date_pkg::slot_1: return digit_pattern(day / 10, 1'b1);
            date_pkg::slot_2: return digit_pattern(month % 10, 1'b0);
            default:          return digit_pattern(month / 10, 1'b1);
        endcase
    endfunction

    function automatic logic [3:0] expected_an(input date_pkg::scan_slot_e slot,
                                               input date_pkg::display_mode_e mode);
        if (mode == date_pkg::mode_year && slot >= date_pkg::slot_2)
            return date_pkg::anode_off;
        return ~(4'b0001 << slot);
    endfunction

    always @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_day            <= 1;
            m_month          <= 1;
            m_year           <= 0;
            m_slot           <= date_pkg::slot_0;
            exp_seg          <= date_pkg::seg_blank;
            exp_an           <= date_pkg::anode_off;
            held_load_digits <= '0;
        end
        else
        begin
            // Display register follows the date held before this edge
            exp_seg          <= expected_seg(m_slot, mode_now, m_day, m_month, m_year);
            exp_an           <= expected_an(m_slot, mode_now);
            m_slot           <= date_pkg::scan_slot_e'(m_slot + 2'd1);
            held_load_digits <= load_digits;
            if (load)
            begin
                m_day   <= int'(load_day_ten) * 10 + int'(load_day_one);
                m_month <= int'(load_month_ten) * 10 + int'(load_month_one);
                m_year  <= int'(load_year_ten) * 10 + int'(load_year_one);
            end
            else if (advance && m_day < days_in(m_month, m_year))
                m_day <= m_day + 1;
            else if (advance)
            begin
                m_day   <= 1;
                m_month <= (m_month == 12) ? 1 : m_month + 1;
                m_year  <= (m_month == 12) ? (m_year + 1) % 100 : m_year;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_seg_model: assert property (@(posedge clk_ctl) disable iff (!checking) seg == exp_seg)
    else
    begin
        $display("CHECK FAILED seg expected %h got %h", $sampled(exp_seg), $sampled(seg));
        error_count++;
    end

    a_an_model: assert property (@(posedge clk_ctl) disable iff (!checking) an == exp_an)
    else
    begin
        $display("CHECK FAILED an expected %h got %h", $sampled(exp_an), $sampled(an));
        error_count++;
    end

    // Dark at release and then slot 0 with the day-one digit of 01/01/00
    a_release: assert property (@(posedge clk_ctl) disable iff (!checking)
        $rose(rst_n) |-> (seg == date_pkg::seg_blank && an == date_pkg::anode_off)
        ##1 (an == 4'b1110 && seg == date_pkg::seg_font[1]))
    else
    begin
        $display("CHECK FAILED an/seg after reset release got %h/%h", $sampled(an), $sampled(seg));
        error_count++;
    end

    a_load_wins: assert property (@(posedge clk_ctl) disable iff (!checking || !rst_n)
        load && advance |=> counter_digits == held_load_digits)
    else
    begin
        $display("CHECK FAILED counter_digits expected %h got %h",
                 $sampled(held_load_digits), $sampled(counter_digits));
        error_count++;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic wait_for_anode(input logic [3:0] pattern, input int limit);
        int count;
        count = 0;
        @(negedge clk_ctl);
        while (an !== pattern && count < limit)
        begin
            @(negedge clk_ctl);
            count++;
        end
        if (an !== pattern)
        begin
            $display("Timed out after %0d cycles waiting for anode pattern %h", limit, pattern);
            error_count++;
        end
    endtask

    task automatic show_scans(input int count);
        repeat (count) wait_for_anode(4'b1110, 8);
    endtask

    task automatic drive_date(input int day, input int month, input int year);
        load_day_ten   <= 4'(day / 10);
        load_day_one   <= 4'(day % 10);
        load_month_ten <= 4'(month / 10);
        load_month_one <= 4'(month % 10);
        load_year_ten  <= 4'(year / 10);
        load_year_one  <= 4'(year % 10);
    endtask

    task automatic load_date(input int day, input int month, input int year);
        @(posedge clk_ctl);
        load <= 1'b1;
        drive_date(day, month, year);
        @(posedge clk_ctl);
        load <= 1'b0;
    endtask

    task automatic advance_days(input int count);
        repeat (count)
        begin
            @(posedge clk_ctl);
            advance <= 1'b1;
        end
        @(posedge clk_ctl);
        advance <= 1'b0;
    endtask

    task automatic set_mode(input bit year_mode);
        @(posedge clk_ctl);
        show_year <= year_mode;
    endtask

    task automatic check_date(input int day, input int month, input int year);
        logic [23:0] expected;
        expected = {4'(day / 10), 4'(day % 10), 4'(month / 10), 4'(month % 10),
                    4'(year / 10), 4'(year % 10)};
        @(negedge clk_ctl);
        assert (counter_digits == expected)
        else
        begin
            $display("CHECK FAILED counter_digits expected %h got %h", expected, counter_digits);
            error_count++;
        end
    endtask

    task automatic random_cycle(input bit force_both);
        int year;
        int month;
        int day;
        year  = $urandom % 100;
        month = 1 + $urandom % 12;
        // Half the loads land on a month end
        day   = ($urandom % 2) ? days_in(month, year) : 1 + $urandom % days_in(month, year);
        @(posedge clk_ctl);
        advance <= force_both || ($urandom % 2 == 0);
        load    <= force_both || ($urandom % 20 == 0);
        drive_date(day, month, year);
        if ($urandom % 24 == 0)
            show_year <= !show_year;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
            $display("test %s passed", name);
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial
    begin
        int errors_before;
        int count;
        void'($urandom(32'heb80));
        advance   = 1'b0;
        load      = 1'b0;
        show_year = 1'b0;
        drive_date(1, 1, 0);

        errors_before = error_count;
        @(negedge clk_ctl);
        checking = 1'b1;
        count = 0;
        while (!rst_n && count < 20)
        begin
            @(negedge clk_ctl);
            count++;
        end
        if (!rst_n)
        begin
            $display("Reset was never released");
            error_count++;
        end
        wait_for_anode(4'b1110, 8);
        finish_test("reset_state", errors_before);

        errors_before = error_count;
        show_scans(2);
        load_date(25, 11, 23);
        check_date(25, 11, 23);
        show_scans(2);
        finish_test("day_month_scan", errors_before);

        errors_before = error_count;
        set_mode(1'b1);
        show_scans(2);
        load_date(14, 3, 5);
        check_date(14, 3, 5);
        show_scans(2);
        set_mode(1'b0);
        show_scans(1);
        finish_test("year_mode", errors_before);

        errors_before = error_count;
        load_date(30, 4, 23);
        advance_days(1);
        check_date(1, 5, 23);
        show_scans(1);
        load_date(31, 12, 23);
        advance_days(1);
        check_date(1, 1, 24);
        set_mode(1'b1);
        show_scans(2);
        set_mode(1'b0);
        load_date(31, 5, 99);
        advance_days(1);
        check_date(1, 6, 99);
        load_date(31, 12, 99);
        advance_days(1);
        check_date(1, 1, 0);
        show_scans(1);
        finish_test("rollover", errors_before);

        errors_before = error_count;
        load_date(28, 2, 24);
        advance_days(1);
        check_date(29, 2, 24);
        load_date(28, 2, 23);
        advance_days(1);
        check_date(1, 3, 23);
        load_date(28, 2, 0);
        advance_days(1);
        check_date(29, 2, 0);
        show_scans(1);
        finish_test("leap_years", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 800; i++)
            random_cycle(i % 40 == 39);
        @(posedge clk_ctl);
        advance <= 1'b0;
        load    <= 1'b0;
        show_scans(2);
        finish_test("random_run", errors_before);

        $display("tests run %0d, with failures %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: date_display.f
verilog/date_pkg.sv
verilog/seg_decoder.sv
verilog/date_counter.sv
verilog/display_scan.sv
verilog/date_display.sv
dv/tb_clock_gen.sv
dv/tb_date_display.sv

// File: Bender.yml
package:
  name: date_display

sources:
  - verilog/date_pkg.sv
  - verilog/seg_decoder.sv
  - verilog/date_counter.sv
  - verilog/display_scan.sv
  - verilog/date_display.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_date_display.sv
